//--- rename_unit.f
verilog/rename_pkg.sv
verilog/free_list.sv
verilog/rename_table.sv
verilog/phys_regfile.sv
verilog/reorder_buffer.sv
verilog/rename_unit.sv
tests/tb_rename_unit.sv

//--- tests/tb_rename_unit.sv
// Rename unit testbench
module tb_rename_unit;
    import rename_pkg::*;

    localparam int ROB_DEPTH   = 8;
    localparam int MAX_SEQ     = 1024;
    localparam int RANDOM_ROWS = 200;

    logic        clk;
    logic        reset;
    logic        flush;
    logic        disp_valid;
    dispatch_t   disp;
    logic        disp_ready;
    logic        iss_valid;
    issue_t      iss;
    logic        iss_ready;
    logic        wb_valid;
    writeback_t  wb;
    logic        cm_valid;
    commit_t     cm;

    // stimulus table
    string       row_name [$];
    dispatch_t   row_disp [$];
    int          row_delay [$];
    int          row_hold [$];
    bit          row_flush [$];

    // model state per instruction, indexed by dispatch sequence number
    dispatch_t   rec_disp [MAX_SEQ];
    int          rec_row [MAX_SEQ];
    data_t       rec_a [MAX_SEQ];
    data_t       rec_b [MAX_SEQ];
    data_t       rec_res [MAX_SEQ];
    int          rec_src1 [MAX_SEQ];
    int          rec_src2 [MAX_SEQ];
    logic [2:0]  rec_line [MAX_SEQ];
    preg_t       rec_prd [MAX_SEQ];
    preg_t       rec_lprd [MAX_SEQ];
    int          rec_hold [MAX_SEQ];
    bit          rec_seen [MAX_SEQ];
    bit          rec_issued [MAX_SEQ];
    bit          rec_done [MAX_SEQ];

    // architectural view in program order and at commit
    data_t       spec_val [ARCH_REGS];
    data_t       com_val [ARCH_REGS];
    preg_t       spec_map [ARCH_REGS];
    preg_t       com_map [ARCH_REGS];
    int          writer [ARCH_REGS];
    int          inflight [$];
    int          fu_seq [$];
    int          fu_due [$];
    data_t       fu_data [$];

    logic [31:0] lfsr;
    int          row;
    int          seq;
    int          rob_ctr;
    int          cycle;
    int          limit;
    bit          flush_now;

    rename_unit #(
        .ROB_DEPTH(ROB_DEPTH)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .disp_valid (disp_valid),
        .disp       (disp),
        .disp_ready (disp_ready),
        .iss_valid  (iss_valid),
        .iss        (iss),
        .iss_ready  (iss_ready),
        .wb_valid   (wb_valid),
        .wb         (wb),
        .cm_valid   (cm_valid),
        .cm         (cm)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_fail();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_issue(string name, issue_t exp, issue_t act);
        if (act !== exp) begin
            $display("FAIL %s: issue expected %h actual %h", name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_commit(string name, commit_t exp, commit_t act);
        if (act !== exp) begin
            $display("FAIL %s: commit expected %h actual %h", name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_bit(string name, string what, logic exp, logic act);
        if (act !== exp) begin
            $display("FAIL %s: %s expected %b actual %b", name, what, exp, act);
            report_fail();
        end
    endtask

    // 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic bit writes_rd(dispatch_t d);
        return d.uses_rd && (d.rd != '0);
    endfunction

    function automatic bit src_ready(int s);
        return (s < 0) || rec_done[s];
    endfunction

    task automatic add_row(string name, int rs1, int rs2, int rd, bit u1, bit u2, bit ud,
                           int op, int delay, int hold, bit fl);
        dispatch_t d;
        d.rs1      = arch_reg_t'(rs1);
        d.rs2      = arch_reg_t'(rs2);
        d.rd       = arch_reg_t'(rd);
        d.uses_rs1 = u1;
        d.uses_rs2 = u2;
        d.uses_rd  = ud;
        d.op       = op_t'(op);
        row_name.push_back(name);
        row_disp.push_back(d);
        row_delay.push_back(delay);
        row_hold.push_back(hold);
        row_flush.push_back(fl);
    endtask

    task automatic build_table();
        int rs1;
        int rs2;
        int rd;
        int op;
        int delay;
        int hold;
        bit u1;
        bit u2;
        bit ud;
        bit fl;
        // dependent chains, x0 handling and missing operands
        add_row("chain_a", 0, 0, 1, 1, 1, 1, 'h05, 1, 0, 0);
        add_row("chain_b", 1, 1, 2, 1, 1, 1, 'h03, 2, 0, 0);
        add_row("chain_c", 2, 1, 3, 1, 1, 1, 'h10, 1, 0, 0);
        add_row("rewrite_x1", 3, 2, 1, 1, 1, 1, 'h01, 3, 0, 0);
        add_row("no_sources", 5, 6, 4, 0, 0, 1, 'h7f, 1, 0, 0);
        add_row("x0_dest", 1, 2, 0, 1, 1, 1, 'h22, 1, 0, 0);
        add_row("no_dest", 1, 4, 7, 1, 1, 0, 'h44, 1, 0, 0);
        add_row("read_x0", 0, 4, 9, 1, 1, 1, 'h0c, 1, 0, 0);
        // blocked issue fills the ROB
        add_row("hold_issue", 1, 2, 5, 1, 1, 1, 'h11, 1, 14, 0);
        for (int i = 0; i < ROB_DEPTH; i++) begin
            add_row($sformatf("fill_rob_%0d", i), 5, i, 10 + i, 1, 1, 1, i, 1, 0, 0);
        end
        // slow producers thrown away by a flush
        add_row("slow_a", 1, 2, 6, 1, 1, 1, 'h09, 12, 0, 0);
        add_row("slow_b", 6, 6, 6, 1, 1, 1, 'h0a, 12, 0, 0);
        add_row("slow_c", 6, 3, 2, 1, 1, 1, 'h0b, 1, 0, 0);
        add_row("after_flush", 6, 2, 8, 1, 1, 1, 'h02, 1, 0, 1);
        add_row("refill", 8, 6, 6, 1, 1, 1, 'h33, 2, 0, 0);
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            rs1   = lfsr_bits(3);
            rs2   = lfsr_bits(3);
            rd    = lfsr_bits(3);
            u1    = lfsr_bits(1);
            u2    = lfsr_bits(1);
            ud    = (lfsr_bits(2) != 0);
            op    = lfsr_bits(8);
            delay = 1 + lfsr_bits(3);
            hold  = (lfsr_bits(2) == 0) ? 2 : 0;
            fl    = (lfsr_bits(4) == 0);
            add_row($sformatf("random_%0d", i), rs1, rs2, rd, u1, u2, ud, op, delay, hold, fl);
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < ARCH_REGS; i++) begin
            spec_val[i] = '0;
            com_val[i]  = '0;
            spec_map[i] = preg_t'(i);
            com_map[i]  = preg_t'(i);
            writer[i]   = -1;
        end
    endtask

    // uncommitted work disappears, committed state becomes current
    task automatic flush_model();
        inflight.delete();
        fu_seq.delete();
        fu_due.delete();
        fu_data.delete();
        for (int i = 0; i < ARCH_REGS; i++) begin
            spec_val[i] = com_val[i];
            spec_map[i] = com_map[i];
            writer[i]   = -1;
        end
        rob_ctr = 0;
    endtask

    task automatic commit_step();
        int      s;
        bit      exp_valid;
        string   nm;
        commit_t exp;
        exp_valid = (inflight.size() > 0) && rec_done[inflight[0]];
        nm = (inflight.size() > 0) ? row_name[rec_row[inflight[0]]] : "idle";
        check_bit(nm, "cm_valid", exp_valid, cm_valid);
        if (cm_valid && !flush_now) begin
            s           = inflight.pop_front();
            exp.rd      = rec_disp[s].rd;
            exp.prd     = rec_prd[s];
            exp.lprd    = rec_lprd[s];
            exp.uses_rd = rec_disp[s].uses_rd;
            check_commit(nm, exp, cm);
            if (writes_rd(rec_disp[s])) begin
                com_val[rec_disp[s].rd] = rec_res[s];
                com_map[rec_disp[s].rd] = rec_prd[s];
            end
        end
    endtask

    // new destination must not alias live or committed state
    task automatic capture_prd(int s);
        string     nm;
        preg_t     p;
        arch_reg_t rd;
        nm          = row_name[rec_row[s]];
        rd          = rec_disp[s].rd;
        p           = iss.prd;
        rec_seen[s] = 1'b1;
        if (writes_rd(rec_disp[s])) begin
            check_bit(nm, "prd nonzero", 1'b1, p != '0);
            foreach (inflight[i]) begin
                if (inflight[i] != s && rec_seen[inflight[i]] &&
                    writes_rd(rec_disp[inflight[i]])) begin
                    check_bit(nm, "prd unique in flight", 1'b1, rec_prd[inflight[i]] != p);
                end
            end
            for (int i = 1; i < ARCH_REGS; i++) begin
                check_bit(nm, "prd not committed", 1'b1, com_map[i] != p);
            end
            rec_prd[s]   = p;
            rec_lprd[s]  = spec_map[rd];
            spec_map[rd] = p;
        end else begin
            rec_prd[s]  = '0;
            rec_lprd[s] = '0;
        end
    endtask

    task automatic issue_step();
        int     s;
        bit     exp_valid;
        string  nm;
        issue_t exp;
        s = -1;
        foreach (inflight[i]) begin
            if (s < 0 && !rec_issued[inflight[i]]) begin
                s = inflight[i];
            end
        end
        exp_valid = (s >= 0) && src_ready(rec_src1[s]) && src_ready(rec_src2[s]);
        nm = (s >= 0) ? row_name[rec_row[s]] : "idle";
        check_bit(nm, "iss_valid", exp_valid, iss_valid);
        iss_ready = 1'b1;
        if (iss_valid) begin
            if (!rec_seen[s]) begin
                capture_prd(s);
            end
            exp.rob_line = rec_line[s];
            exp.prd      = rec_prd[s];
            exp.rs1_data = rec_a[s];
            exp.rs2_data = rec_b[s];
            exp.op       = rec_disp[s].op;
            check_issue(nm, exp, iss);
            if (rec_hold[s] > 0) begin
                iss_ready   = 1'b0;
                rec_hold[s] = rec_hold[s] - 1;
            end else if (!flush_now) begin
                rec_issued[s] = 1'b1;
                fu_seq.push_back(s);
                fu_due.push_back(cycle + row_delay[rec_row[s]]);
                fu_data.push_back(iss.rs1_data + iss.rs2_data + data_t'(iss.op));
            end
        end
    endtask

    // functional unit returns the first result whose delay is over
    task automatic writeback_step();
        int pick;
        int s;
        pick     = -1;
        wb_valid = 1'b0;
        if (!flush_now) begin
            foreach (fu_seq[i]) begin
                if (pick < 0 && fu_due[i] <= cycle) begin
                    pick = i;
                end
            end
        end
        if (pick >= 0) begin
            s           = fu_seq[pick];
            wb_valid    = 1'b1;
            wb.rob_line = rec_line[s];
            wb.prd      = rec_prd[s];
            wb.data     = fu_data[pick];
            rec_done[s] = 1'b1;
            fu_seq.delete(pick);
            fu_due.delete(pick);
            fu_data.delete(pick);
        end
    endtask

    task automatic dispatch_step();
        int        s;
        dispatch_t d;
        disp_valid = 1'b0;
        flush      = 1'b0;
        if (row < row_name.size()) begin
            if (flush_now) begin
                flush          = 1'b1;
                row_flush[row] = 1'b0;
                flush_model();
            end else begin
                d          = row_disp[row];
                disp_valid = 1'b1;
                disp       = d;
                if (disp_ready) begin
                    s             = seq;
                    seq           = seq + 1;
                    rec_disp[s]   = d;
                    rec_row[s]    = row;
                    rec_hold[s]   = row_hold[row];
                    rec_seen[s]   = 1'b0;
                    rec_issued[s] = 1'b0;
                    rec_done[s]   = 1'b0;
                    rec_a[s]      = d.uses_rs1 ? spec_val[d.rs1] : '0;
                    rec_b[s]      = d.uses_rs2 ? spec_val[d.rs2] : '0;
                    rec_src1[s]   = d.uses_rs1 ? writer[d.rs1] : -1;
                    rec_src2[s]   = d.uses_rs2 ? writer[d.rs2] : -1;
                    rec_res[s]    = rec_a[s] + rec_b[s] + data_t'(d.op);
                    rec_line[s]   = 3'(rob_ctr % ROB_DEPTH);
                    rob_ctr       = rob_ctr + 1;
                    if (writes_rd(d)) begin
                        spec_val[d.rd] = rec_res[s];
                        writer[d.rd]   = s;
                    end
                    inflight.push_back(s);
                    row = row + 1;
                end
            end
        end
    endtask

    initial begin
        string nm;
        lfsr       = 32'h10c60f9e;
        reset      = 1'b1;
        flush      = 1'b0;
        disp_valid = 1'b0;
        disp       = '0;
        iss_ready  = 1'b0;
        wb_valid   = 1'b0;
        wb         = '0;
        build_table();
        reset_model();
        row     = 0;
        seq     = 0;
        rob_ctr = 0;
        cycle   = 0;
        limit   = 20 * row_name.size() + 100;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        check_bit("reset", "disp_ready", 1'b1, disp_ready);
        check_bit("reset", "iss_valid", 1'b0, iss_valid);
        check_bit("reset", "cm_valid", 1'b0, cm_valid);
        iss_ready = 1'b1;
        while (row < row_name.size() || inflight.size() > 0) begin
            @(posedge clk);
            #1;
            cycle = cycle + 1;
            if (cycle > limit) begin
                $display("timeout after %0d cycles, %0d instructions still in flight",
                         cycle, inflight.size());
                report_fail();
            end
            flush_now = (row < row_name.size()) && row_flush[row];
            nm = (row < row_name.size()) ? row_name[row] : "drain";
            // ROB full is the only dispatch stall here
            check_bit(nm, "disp_ready", inflight.size() < ROB_DEPTH, disp_ready);
            commit_step();
            issue_step();
            writeback_step();
            dispatch_step();
        end
        @(posedge clk);
        #1;
        check_bit("drain", "cm_valid", 1'b0, cm_valid);
        check_bit("drain", "iss_valid", 1'b0, iss_valid);
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- verilog/free_list.sv
// Physical register free list
module free_list #(
    parameter int DEPTH = 32
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              alloc,
    output rename_pkg::preg_t alloc_preg,
    output logic              empty,
    input  logic              release_en,
    input  rename_pkg::preg_t release_preg,
    input  logic              commit_alloc
);
    import rename_pkg::*;

    localparam int PW = $clog2(DEPTH);

    preg_t       slots [DEPTH];
    // pointers carry one wrap bit so that full and empty differ
    logic [PW:0] wr_ptr;
    logic [PW:0] rd_ptr;
    logic [PW:0] cm_rd_ptr;
    logic [PW:0] count;

    assign count      = wr_ptr - rd_ptr;
    assign empty      = (count == '0);
    assign alloc_preg = slots[rd_ptr[PW-1:0]];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= (PW + 1)'(DEPTH);
            rd_ptr    <= '0;
            cm_rd_ptr <= '0;
        end else if (flush) begin
            // hand back everything taken by uncommitted instructions
            rd_ptr <= cm_rd_ptr;
        end else begin
            if (alloc) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (release_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (commit_alloc) begin
                cm_rd_ptr <= cm_rd_ptr + 1'b1;
            end
        end
    end

    // starts out holding the registers above the architectural ones
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                slots[i] <= preg_t'(ARCH_REGS + i);
            end
        end else if (release_en && !flush) begin
            slots[wr_ptr[PW-1:0]] <= release_preg;
        end
    end

    a_no_alloc_empty: assert property (@(posedge clk) disable iff (reset)
        alloc |-> !empty);

    a_no_release_full: assert property (@(posedge clk) disable iff (reset)
        release_en |-> count != (PW + 1)'(DEPTH));

endmodule

//--- verilog/phys_regfile.sv
// Physical register file with ready bits
module phys_regfile (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          flush,
    input  rename_pkg::preg_t [rename_pkg::ARCH_REGS-1:0] committed_pregs,
    input  rename_pkg::preg_t                             raddr1,
    input  rename_pkg::preg_t                             raddr2,
    output rename_pkg::data_t                             rdata1,
    output rename_pkg::data_t                             rdata2,
    output logic                                          rready1,
    output logic                                          rready2,
    input  logic                                          alloc_en,
    input  rename_pkg::preg_t                             alloc_preg,
    input  logic                                          wb_valid,
    input  rename_pkg::writeback_t                        wb
);
    import rename_pkg::*;

    data_t                regs [NUM_PREGS];
    logic [NUM_PREGS-1:0] ready;

    // p0 is never written, so it reads as zero
    assign rdata1  = regs[raddr1];
    assign rdata2  = regs[raddr2];
    assign rready1 = ready[raddr1] || (raddr1 == '0);
    assign rready2 = ready[raddr2] || (raddr2 == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && !flush && wb.prd != '0) begin
            regs[wb.prd] <= wb.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= '1;
        end else if (flush) begin
            // committed mappings hold architectural state
            for (int i = 0; i < ARCH_REGS; i++) begin
                ready[committed_pregs[i]] <= 1'b1;
            end
        end else begin
            if (alloc_en) begin
                ready[alloc_preg] <= 1'b0;
            end
            if (wb_valid) begin
                ready[wb.prd] <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/rename_pkg.sv
// Register rename package
package rename_pkg;

    localparam int ARCH_REGS = 32;
    localparam int NUM_PREGS = 64;

    typedef logic [4:0]  arch_reg_t;
    typedef logic [5:0]  preg_t;
    typedef logic [63:0] data_t;
    typedef logic [7:0]  op_t;

    // decoded instruction from decode
    typedef struct packed {
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        logic      uses_rs1;
        logic      uses_rs2;
        logic      uses_rd;
        op_t       op;
    } dispatch_t;

    // operands handed to the functional unit
    typedef struct packed {
        logic [2:0] rob_line;
        preg_t      prd;
        data_t      rs1_data;
        data_t      rs2_data;
        op_t        op;
    } issue_t;

    typedef struct packed {
        logic [2:0] rob_line;
        preg_t      prd;
        data_t      data;
    } writeback_t;

    // lprd is the mapping that goes back to the free list
    typedef struct packed {
        arch_reg_t rd;
        preg_t     prd;
        preg_t     lprd;
        logic      uses_rd;
    } commit_t;

endpackage

//--- verilog/rename_table.sv
// Architectural to physical register maps
module rename_table (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          flush,
    input  rename_pkg::arch_reg_t                         rs1,
    input  rename_pkg::arch_reg_t                         rs2,
    input  rename_pkg::arch_reg_t                         rd,
    output rename_pkg::preg_t                             prs1,
    output rename_pkg::preg_t                             prs2,
    output rename_pkg::preg_t                             lprd,
    input  logic                                          rename_en,
    input  rename_pkg::preg_t                             new_prd,
    input  logic                                          commit_en,
    input  rename_pkg::commit_t                           commit,
    output rename_pkg::preg_t [rename_pkg::ARCH_REGS-1:0] committed_pregs
);
    import rename_pkg::*;

    preg_t [ARCH_REGS-1:0] spec_map;

    // lookups see the map before this instruction's own rename
    assign prs1 = spec_map[rs1];
    assign prs2 = spec_map[rs2];
    assign lprd = spec_map[rd];

    // speculative map
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                spec_map[i] <= preg_t'(i);
            end
        end else if (flush) begin
            spec_map <= committed_pregs;
        end else if (rename_en && rd != '0) begin
            spec_map[rd] <= new_prd;
        end
    end

    // committed map, x0 stays on p0
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                committed_pregs[i] <= preg_t'(i);
            end
        end else if (!flush && commit_en && commit.uses_rd && commit.rd != '0) begin
            committed_pregs[commit.rd] <= commit.prd;
        end
    end

endmodule

//--- verilog/rename_unit.sv
// Register rename and reorder unit
module rename_unit #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   disp_valid,
    input  rename_pkg::dispatch_t  disp,
    output logic                   disp_ready,
    output logic                   iss_valid,
    output rename_pkg::issue_t     iss,
    input  logic                   iss_ready,
    input  logic                   wb_valid,
    input  rename_pkg::writeback_t wb,
    output logic                   cm_valid,
    output rename_pkg::commit_t    cm
);
    import rename_pkg::*;

    localparam int FREE_DEPTH = NUM_PREGS - ARCH_REGS;

    logic                  alloc;
    preg_t                 alloc_preg;
    logic                  fl_empty;
    logic                  cm_release;
    preg_t                 map_prs1;
    preg_t                 map_prs2;
    preg_t                 map_lprd;
    preg_t [ARCH_REGS-1:0] committed_pregs;
    preg_t                 raddr1;
    preg_t                 raddr2;
    data_t                 rdata1;
    data_t                 rdata2;
    logic                  rready1;
    logic                  rready2;

    // every committed allocation also frees the old mapping
    free_list #(
        .DEPTH(FREE_DEPTH)
    ) u_free_list (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .alloc        (alloc),
        .alloc_preg   (alloc_preg),
        .empty        (fl_empty),
        .release_en   (cm_release),
        .release_preg (cm.lprd),
        .commit_alloc (cm_release)
    );

    rename_table u_rename_table (
        .clk             (clk),
        .reset           (reset),
        .flush           (flush),
        .rs1             (disp.rs1),
        .rs2             (disp.rs2),
        .rd              (disp.rd),
        .prs1            (map_prs1),
        .prs2            (map_prs2),
        .lprd            (map_lprd),
        .rename_en       (alloc),
        .new_prd         (alloc_preg),
        .commit_en       (cm_valid),
        .commit          (cm),
        .committed_pregs (committed_pregs)
    );

    phys_regfile u_phys_regfile (
        .clk             (clk),
        .reset           (reset),
        .flush           (flush),
        .committed_pregs (committed_pregs),
        .raddr1          (raddr1),
        .raddr2          (raddr2),
        .rdata1          (rdata1),
        .rdata2          (rdata2),
        .rready1         (rready1),
        .rready2         (rready2),
        .alloc_en        (alloc),
        .alloc_preg      (alloc_preg),
        .wb_valid        (wb_valid),
        .wb              (wb)
    );

    reorder_buffer #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_reorder_buffer (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .disp_valid (disp_valid),
        .disp       (disp),
        .disp_ready (disp_ready),
        .iss_valid  (iss_valid),
        .iss        (iss),
        .iss_ready  (iss_ready),
        .wb_valid   (wb_valid),
        .wb         (wb),
        .cm_valid   (cm_valid),
        .cm         (cm),
        .alloc      (alloc),
        .alloc_preg (alloc_preg),
        .fl_empty   (fl_empty),
        .cm_release (cm_release),
        .map_prs1   (map_prs1),
        .map_prs2   (map_prs2),
        .map_lprd   (map_lprd),
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .rready1    (rready1),
        .rready2    (rready2)
    );

endmodule

//--- verilog/reorder_buffer.sv
// Reorder buffer with in-order issue and commit
module reorder_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   disp_valid,
    input  rename_pkg::dispatch_t  disp,
    output logic                   disp_ready,
    output logic                   iss_valid,
    output rename_pkg::issue_t     iss,
    input  logic                   iss_ready,
    input  logic                   wb_valid,
    input  rename_pkg::writeback_t wb,
    output logic                   cm_valid,
    output rename_pkg::commit_t    cm,
    output logic                   alloc,
    input  rename_pkg::preg_t      alloc_preg,
    input  logic                   fl_empty,
    output logic                   cm_release,
    input  rename_pkg::preg_t      map_prs1,
    input  rename_pkg::preg_t      map_prs2,
    input  rename_pkg::preg_t      map_lprd,
    output rename_pkg::preg_t      raddr1,
    output rename_pkg::preg_t      raddr2,
    input  rename_pkg::data_t      rdata1,
    input  rename_pkg::data_t      rdata2,
    input  logic                   rready1,
    input  logic                   rready2
);
    import rename_pkg::*;

    localparam int PTR_W = $clog2(ROB_DEPTH);

    typedef struct packed {
        arch_reg_t rd;
        logic      uses_rd;
        preg_t     prs1;
        preg_t     prs2;
        preg_t     prd;
        preg_t     lprd;
        op_t       op;
    } rob_entry_t;

    rob_entry_t             entries [ROB_DEPTH];
    rob_entry_t             new_entry;
    rob_entry_t             iss_entry;
    rob_entry_t             cm_entry;
    logic [ROB_DEPTH-1:0]   used;
    logic [ROB_DEPTH-1:0]   issued;
    logic [ROB_DEPTH-1:0]   finished;
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       iss_ptr;
    logic [PTR_W-1:0]       cm_ptr;
    logic                   writes_rd;
    logic                   disp_fire;
    logic                   iss_fire;
    logic                   cm_fire;

    // x0 destinations get no physical register
    assign writes_rd  = disp.uses_rd && (disp.rd != '0);
    assign disp_ready = !used[wr_ptr] && !fl_empty;
    assign disp_fire  = disp_valid && disp_ready && !flush;
    assign alloc      = disp_fire && writes_rd;

    always_comb begin
        new_entry.rd      = disp.rd;
        new_entry.uses_rd = disp.uses_rd;
        // unused sources point at p0, which is always ready
        new_entry.prs1    = disp.uses_rs1 ? map_prs1 : '0;
        new_entry.prs2    = disp.uses_rs2 ? map_prs2 : '0;
        new_entry.prd     = writes_rd ? alloc_preg : '0;
        new_entry.lprd    = writes_rd ? map_lprd : '0;
        new_entry.op      = disp.op;
    end

    // issue from the oldest unissued entry
    assign iss_entry = entries[iss_ptr];
    assign raddr1    = iss_entry.prs1;
    assign raddr2    = iss_entry.prs2;
    assign iss_valid = used[iss_ptr] && !issued[iss_ptr] && rready1 && rready2;
    assign iss_fire  = iss_valid && iss_ready && !flush;

    always_comb begin
        iss.rob_line = iss_ptr;
        iss.prd      = iss_entry.prd;
        iss.rs1_data = rdata1;
        iss.rs2_data = rdata2;
        iss.op       = iss_entry.op;
    end

    // commit from the head
    assign cm_entry   = entries[cm_ptr];
    assign cm_valid   = used[cm_ptr] && finished[cm_ptr];
    assign cm_fire    = cm_valid && !flush;
    assign cm_release = cm_fire && (cm_entry.prd != '0);

    always_comb begin
        cm.rd      = cm_entry.rd;
        cm.prd     = cm_entry.prd;
        cm.lprd    = cm_entry.lprd;
        cm.uses_rd = cm_entry.uses_rd;
    end

    always_ff @(posedge clk) begin
        if (disp_fire) begin
            entries[wr_ptr] <= new_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            used     <= '0;
            issued   <= '0;
            finished <= '0;
            wr_ptr   <= '0;
            iss_ptr  <= '0;
            cm_ptr   <= '0;
        end else begin
            if (disp_fire) begin
                used[wr_ptr]     <= 1'b1;
                issued[wr_ptr]   <= 1'b0;
                finished[wr_ptr] <= 1'b0;
                wr_ptr           <= wr_ptr + 1'b1;
            end
            if (iss_fire) begin
                issued[iss_ptr] <= 1'b1;
                iss_ptr         <= iss_ptr + 1'b1;
            end
            if (wb_valid) begin
                finished[wb.rob_line] <= 1'b1;
            end
            // head and tail slots never coincide here
            if (cm_fire) begin
                used[cm_ptr]     <= 1'b0;
                issued[cm_ptr]   <= 1'b0;
                finished[cm_ptr] <= 1'b0;
                cm_ptr           <= cm_ptr + 1'b1;
            end
        end
    end

    // tail may only land on the head slot when the buffer is empty
    a_no_disp_full: assert property (@(posedge clk) disable iff (reset)
        disp_fire |-> (wr_ptr != cm_ptr) || !(|used));

    a_wb_in_flight: assert property (@(posedge clk) disable iff (reset || flush)
        wb_valid |-> used[wb.rob_line] && issued[wb.rob_line]);

endmodule
